//--- hw/tx_settings.svh
// transmit path settings: sample widths, accelerator FIFO geometry, CDC depth
`ifndef TX_SETTINGS_SVH
`define TX_SETTINGS_SVH

// one I or Q component as the DAC takes it
`define TX_IQ_WIDTH 16

// packed DAC word, two antenna lanes of I/Q
`define TX_DAC_WORD_WIDTH 64

// accelerator sample FIFO
// depth must stay a power of two for the Gray pointers
`define TX_FIFO_DEPTH 32

// log2 of the depth
`define TX_FIFO_ADDR_WIDTH 5

// destination flops in the control synchronizer
// source side always adds one register on top
`define TX_SYNC_STAGES 4

`endif

//--- hw/tx_sample_pkg.sv
// sample types: single antenna I/Q and the packed two-lane DAC word
`default_nettype none

`include "tx_settings.svh"

package tx_sample_pkg;

    // one antenna sample, also one entry of the accelerator FIFO
    // i sits in the upper half
    typedef struct packed {
        logic [`TX_IQ_WIDTH-1:0] i;
        logic [`TX_IQ_WIDTH-1:0] q;
    } iq_sample_t;

    // lane layout of the DAC word
    // ant1 in the upper 32 bits, ant0 in the lower
    typedef struct packed {
        iq_sample_t ant1;
        iq_sample_t ant0;
    } dac_lanes_t;

    // same 64 bits seen two ways
    // DMA words arrive already packed, so they pass as raw
    // accelerator words get assembled lane by lane
    typedef union packed {
        logic [`TX_DAC_WORD_WIDTH-1:0] raw;
        dac_lanes_t                    lanes;
    } dac_word_t;

endpackage

`default_nettype wire

//--- hw/tx_ctrl_pkg.sv
// control types: path select and FIFO status flags
`default_nettype none

package tx_ctrl_pkg;

    // path control, written by software in the accelerator domain
    // src_sel: 0 for DMA, 1 for accelerator
    // ant_flag: 0 for lane ant0, 1 for lane ant1
    typedef struct packed {
        logic src_sel;
        logic ant_flag;
    } path_ctrl_t;

    // FIFO flags
    // empty belongs to the read clock, full to the write clock
    typedef struct packed {
        logic empty;
        logic full;
    } fifo_status_t;

endpackage

`default_nettype wire

//--- hw/cdc_flag_sync.sv
// control synchronizer: moves the path control struct from acc_clk into dac_clk
`timescale 1ns/1ps
`default_nettype none

`include "tx_settings.svh"

module cdc_flag_sync (
    input  wire logic                    acc_clk,
    input  wire logic                    dac_clk,
    input  wire logic                    rst_n,
    input  wire tx_ctrl_pkg::path_ctrl_t ctrl_in,
    output tx_ctrl_pkg::path_ctrl_t      ctrl_acc,
    output tx_ctrl_pkg::path_ctrl_t      ctrl_dac
);

    localparam int STAGES = `TX_SYNC_STAGES;

    // flop chain in the DAC domain, stage 0 is the metastable one
    tx_ctrl_pkg::path_ctrl_t [STAGES-1:0] sync_q;

    // source register
    // keeps glitches from the software side off the crossing
    // also used locally for write gating
    always_ff @(posedge acc_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_acc <= '0;
        end else begin
            ctrl_acc <= ctrl_in;
        end
    end

    // destination chain
    // bits are allowed to land on different cycles
    // since software only touches ctrl while traffic is idle
    always_ff @(posedge dac_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], ctrl_acc};
        end
    end

    // last stage is the settled copy
    assign ctrl_dac = sync_q[STAGES-1];

endmodule

`default_nettype wire

//--- hw/iq_async_fifo.sv
// dual-clock FWFT FIFO of I/Q samples with Gray-coded pointer crossing
`timescale 1ns/1ps
`default_nettype none

`include "tx_settings.svh"

module iq_async_fifo (
    input  wire logic                      wr_clk,
    input  wire logic                      rd_clk,
    input  wire logic                      rst_n,
    input  wire logic                      wr_en,
    input  wire tx_sample_pkg::iq_sample_t wr_data,
    input  wire logic                      rd_en,
    output tx_sample_pkg::iq_sample_t      rd_data,
    output tx_ctrl_pkg::fifo_status_t      status
);

    localparam int AW = `TX_FIFO_ADDR_WIDTH;

    // sample storage written on wr_clk and read asynchronously
    tx_sample_pkg::iq_sample_t mem [`TX_FIFO_DEPTH];

    // write domain
    logic [AW:0] wr_bin;
    logic [AW:0] wr_gray;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray_next;
    logic [AW:0] rd_gray_s1;
    logic [AW:0] rd_gray_s2;
    logic        wr_full;
    logic        wr_ok;

    // read domain
    logic [AW:0] rd_bin;
    logic [AW:0] rd_gray;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray_next;
    logic [AW:0] wr_gray_s1;
    logic [AW:0] wr_gray_s2;
    logic        rd_empty;
    logic        rd_ok;

    // write side
    // full guard lives here so the caller may offer writes freely
    assign wr_ok = wr_en && !wr_full;

    assign wr_bin_next  = wr_bin + {{AW{1'b0}}, wr_ok};
    // binary to Gray
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
        end
    end

    // storage write
    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    // read pointer into the write clock through two flops
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // full when writer is one lap ahead
    // in Gray that means top two bits inverted and the rest equal
    // left unregistered so space frees 2 to 3 wr_clk after a pop
    assign wr_full = (wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});

    // read side
    // empty guard also local
    assign rd_ok = rd_en && !rd_empty;

    assign rd_bin_next  = rd_bin + {{AW{1'b0}}, rd_ok};
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
        end
    end

    // write pointer into read clock
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // empty on exact pointer match
    // a write shows up 2 to 3 rd_clk later
    assign rd_empty = (rd_gray == wr_gray_s2);

    // first word fall through with the head entry straight out
    // contents are stale while empty and the caller masks them
    assign rd_data = mem[rd_bin[AW-1:0]];

    assign status = '{empty: rd_empty, full: wr_full};

endmodule

`default_nettype wire

//--- hw/dac_intf.sv
// DAC transmit interface: picks DMA or accelerator samples and packs the DAC word
`timescale 1ns/1ps
`default_nettype none

`include "tx_settings.svh"

module dac_intf (
    input  wire logic                      dac_clk,
    input  wire logic                      acc_clk,
    input  wire logic                      rst_n,

    // DAC side
    input  wire logic                      dac_valid,
    output tx_sample_pkg::dac_word_t       dac_data,
    output logic                           dac_dunf,

    // external DMA FIFO, read on dac_clk
    output logic                           fifo_rd_en,
    input  wire logic [`TX_DAC_WORD_WIDTH-1:0] fifo_rd_dout,
    input  wire logic                      fifo_rd_underflow,

    // accelerator side
    input  wire tx_ctrl_pkg::path_ctrl_t   ctrl,
    input  wire tx_sample_pkg::iq_sample_t data_from_acc,
    input  wire logic                      data_valid_from_acc,
    output logic                           fulln_to_acc
);

    // control copies per domain
    tx_ctrl_pkg::path_ctrl_t   ctrl_acc;
    tx_ctrl_pkg::path_ctrl_t   ctrl_dac;

    // internal FIFO
    tx_sample_pkg::iq_sample_t acc_head;
    tx_ctrl_pkg::fifo_status_t acc_status;
    logic                      acc_wr_en;
    logic                      acc_rd_en;

    // accelerator word after lane placement
    tx_sample_pkg::dac_word_t  acc_word;

    cdc_flag_sync u_sync (
        .acc_clk  (acc_clk),
        .dac_clk  (dac_clk),
        .rst_n    (rst_n),
        .ctrl_in  (ctrl),
        .ctrl_acc (ctrl_acc),
        .ctrl_dac (ctrl_dac)
    );

    // write gating from the acc-domain copy, nothing crosses here
    // full is handled inside the FIFO
    assign acc_wr_en    = data_valid_from_acc && ctrl_acc.src_sel;
    assign fulln_to_acc = !acc_status.full;

    iq_async_fifo u_fifo (
        .wr_clk  (acc_clk),
        .rd_clk  (dac_clk),
        .rst_n   (rst_n),
        .wr_en   (acc_wr_en),
        .wr_data (data_from_acc),
        .rd_en   (acc_rd_en),
        .rd_data (acc_head),
        .status  (acc_status)
    );

    // lane placement
    // selected lane gets the head sample, other lane zero
    // both zero when nothing is queued
    always_comb begin
        acc_word.raw = '0;
        if (!acc_status.empty) begin
            if (ctrl_dac.ant_flag) begin
                acc_word.lanes.ant1 = acc_head;
            end else begin
                acc_word.lanes.ant0 = acc_head;
            end
        end
    end

    // source mux, zero latency
    // pop and underflow go to whichever source is live
    always_comb begin
        if (ctrl_dac.src_sel) begin
            dac_data   = acc_word;
            fifo_rd_en = 1'b0;
            acc_rd_en  = dac_valid;
            dac_dunf   = acc_status.empty;
        end else begin
            // DMA word goes out untouched
            dac_data.raw = fifo_rd_dout;
            fifo_rd_en   = dac_valid;
            acc_rd_en    = 1'b0;
            dac_dunf     = fifo_rd_underflow;
        end
    end

endmodule

`default_nettype wire

//--- testbench/dac_tx_props.sv
// handshake and output properties of the DAC transmit interface bound into dac_intf
`timescale 1ns/1ps
`default_nettype none

module dac_tx_props (
    input wire logic                     dac_clk,
    input wire logic                     acc_clk,
    input wire logic                     rst_n,
    input wire logic                     dac_valid,
    input wire tx_sample_pkg::dac_word_t dac_data,
    input wire logic                     dac_dunf,
    input wire logic                     fifo_rd_en,
    input wire logic                     fifo_rd_underflow,
    input wire logic                     fulln_to_acc,
    input wire logic                     src_sel,
    input wire logic                     ant_flag
);

    // property failures so far
    int unsigned fail_count = 0;

    // out of reset the writer may send
    reset_fulln: assert property (@(posedge acc_clk) $rose(rst_n) |-> fulln_to_acc)
        else begin
            fail_count++;
            $error("fulln_to_acc low right after reset");
        end

    // out of reset the DMA pop tracks the DAC
    reset_dma_pop: assert property (@(posedge dac_clk) $rose(rst_n) |-> fifo_rd_en == dac_valid)
        else begin
            fail_count++;
            $error("fifo_rd_en differs from dac_valid after reset");
        end

    // one DMA pop per DAC take in DMA mode
    dma_pop: assert property (@(posedge dac_clk) disable iff (!rst_n)
        !src_sel |-> fifo_rd_en == dac_valid)
        else begin
            fail_count++;
            $error("DMA pop does not follow dac_valid");
        end

    // accelerator mode leaves the DMA FIFO alone
    acc_no_dma_pop: assert property (@(posedge dac_clk) disable iff (!rst_n)
        src_sel |-> !fifo_rd_en)
        else begin
            fail_count++;
            $error("DMA FIFO popped in accelerator mode");
        end

    dma_underflow: assert property (@(posedge dac_clk) disable iff (!rst_n)
        !src_sel |-> dac_dunf == fifo_rd_underflow)
        else begin
            fail_count++;
            $error("dac_dunf does not follow the DMA underflow");
        end

    // empty internal FIFO gives an all-zero word
    acc_underflow_zero: assert property (@(posedge dac_clk) disable iff (!rst_n)
        src_sel && dac_dunf |-> dac_data.raw == '0)
        else begin
            fail_count++;
            $error("nonzero word during accelerator underflow");
        end

    // lane not picked by ant_flag stays zero
    idle_lane_zero: assert property (@(posedge dac_clk) disable iff (!rst_n)
        src_sel |-> (ant_flag ? dac_data.lanes.ant0 : dac_data.lanes.ant1) == '0)
        else begin
            fail_count++;
            $error("unselected antenna lane carries data");
        end

endmodule

// control bits taken from the synchronized copy inside dac_intf
bind dac_intf dac_tx_props props (
    .dac_clk           (dac_clk),
    .acc_clk           (acc_clk),
    .rst_n             (rst_n),
    .dac_valid         (dac_valid),
    .dac_data          (dac_data),
    .dac_dunf          (dac_dunf),
    .fifo_rd_en        (fifo_rd_en),
    .fifo_rd_underflow (fifo_rd_underflow),
    .fulln_to_acc      (fulln_to_acc),
    .src_sel           (ctrl_dac.src_sel),
    .ant_flag          (ctrl_dac.ant_flag)
);

`default_nettype wire

//--- testbench/dac_tx_tb.sv
// testbench for the DAC transmit interface: DMA passthrough, accelerator lanes, full and underflow
`timescale 1ns/1ps
`default_nettype none

`include "tx_settings.svh"

module dac_tx_tb;

    // sequence needs a few hundred dac_clk cycles
    localparam int MAX_CYCLES = 2000;

    logic                          dac_clk;
    logic                          acc_clk;
    logic                          rst_n;
    logic                          dac_valid;
    tx_sample_pkg::dac_word_t      dac_data;
    logic                          dac_dunf;
    logic                          fifo_rd_en;
    logic [`TX_DAC_WORD_WIDTH-1:0] fifo_rd_dout;
    logic                          fifo_rd_underflow;
    tx_ctrl_pkg::path_ctrl_t       ctrl;
    tx_sample_pkg::iq_sample_t     data_from_acc;
    logic                          data_valid_from_acc;
    logic                          fulln_to_acc;

    // DMA FIFO model, head shown first-word-fall-through
    logic [`TX_DAC_WORD_WIDTH-1:0] dma_q[$];
    // accepted accelerator samples in write order
    tx_sample_pkg::iq_sample_t     sb[$];

    logic [31:0] rng_state;
    int          err_cnt;
    int          accepted;
    int          cycle_cnt;
    logic        check_en;
    // mode the DAC side is known to have settled on
    logic        acc_mode;
    logic        ant_sel;

    dac_intf dut (.*);

    initial begin
        dac_clk = 1'b0;
        forever #20 dac_clk = ~dac_clk;
    end

    initial begin
        acc_clk = 1'b0;
        forever #14 acc_clk = ~acc_clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            err_cnt++;
            $display("FAIL at %0t: %s", $time, msg);
        end
    endtask

    // one DAC cycle: drive on the falling edge, check a little later, before the rising edge
    task automatic dac_tick(input logic valid);
        tx_sample_pkg::dac_word_t exp_word;
        @(negedge dac_clk);
        dac_valid         = valid;
        fifo_rd_underflow = (dma_q.size() == 0);
        fifo_rd_dout      = (dma_q.size() == 0) ? '0 : dma_q[0];
        #2;
        if (check_en && !acc_mode) begin
            expect_true(dac_data.raw == fifo_rd_dout,
                        $sformatf("DMA word %h, expected %h", dac_data.raw, fifo_rd_dout));
            expect_true(fifo_rd_en == valid, "fifo_rd_en does not follow dac_valid");
            expect_true(dac_dunf == fifo_rd_underflow, "dac_dunf differs from DMA underflow");
            if (fifo_rd_en && dma_q.size() > 0) begin
                void'(dma_q.pop_front());
            end
        end else if (check_en) begin
            expect_true(!fifo_rd_en, "fifo_rd_en high in accelerator mode");
            // nothing accepted and unread means the FIFO must look empty
            if (sb.size() == 0) begin
                expect_true(dac_dunf, "no underflow while nothing is queued");
            end
            if (dac_dunf) begin
                expect_true(dac_data.raw == '0,
                            $sformatf("underflow word %h is not zero", dac_data.raw));
            end else if (sb.size() > 0) begin
                exp_word.raw = '0;
                if (ant_sel) begin
                    exp_word.lanes.ant1 = sb[0];
                end else begin
                    exp_word.lanes.ant0 = sb[0];
                end
                expect_true(dac_data.raw == exp_word.raw,
                            $sformatf("acc word %h, expected %h", dac_data.raw, exp_word.raw));
                if (valid) begin
                    void'(sb.pop_front());
                end
            end
        end
    endtask

    // one accelerator cycle, records the write if the rising edge will take it
    task automatic acc_tick(input logic valid);
        @(negedge acc_clk);
        data_valid_from_acc = valid;
        data_from_acc       = valid ? next_rand() : '0;
        #2;
        if (valid && fulln_to_acc && ctrl.src_sel) begin
            sb.push_back(data_from_acc);
            accepted++;
        end
    endtask

    // ctrl changes only while idle, then the DAC side gets 8 cycles to settle
    task automatic set_path(input logic src, input logic ant);
        check_en = 1'b0;
        @(negedge acc_clk);
        ctrl.src_sel  = src;
        ctrl.ant_flag = ant;
        repeat (8) dac_tick(1'b0);
        acc_mode = src;
        ant_sel  = ant;
        check_en = 1'b1;
    endtask

    // run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge dac_clk);
            cycle_cnt++;
        end
        $display("timeout: run still going after %0d dac_clk cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n               = 1'b0;
        dac_valid           = 1'b0;
        fifo_rd_dout        = '0;
        fifo_rd_underflow   = 1'b0;
        ctrl                = '0;
        data_from_acc       = '0;
        data_valid_from_acc = 1'b0;
        err_cnt             = 0;
        accepted            = 0;
        check_en            = 1'b0;
        acc_mode            = 1'b0;
        ant_sel             = 1'b0;
        rng_state           = 32'd80779;
        repeat (24) dma_q.push_back({next_rand(), next_rand()});
        repeat (2) @(negedge dac_clk);
        rst_n    = 1'b1;
        check_en = 1'b1;
        // idle after reset, DMA mode
        repeat (4) dac_tick(1'b0);
        // DMA passthrough, runs past the model contents into underflow
        repeat (30) dac_tick(1'b1);
        expect_true(dma_q.size() == 0, "DMA model not drained");
        // accelerator on ant0, fill with the reader idle
        set_path(1'b1, 1'b0);
        repeat (40) acc_tick(1'b1);
        acc_tick(1'b0);
        expect_true(accepted == 32, $sformatf("%0d writes accepted, expected 32", accepted));
        expect_true(!fulln_to_acc, "fulln_to_acc still high with the FIFO full");
        // drain in order, dropped samples must not show up
        repeat (40) dac_tick(1'b1);
        expect_true(sb.size() == 0, $sformatf("%0d samples never read out", sb.size()));
        // underflow with the FIFO empty
        repeat (4) dac_tick(1'b1);
        expect_true(fulln_to_acc, "fulln_to_acc low after the FIFO drained");
        // steer to ant1 while reading and writing together
        set_path(1'b1, 1'b1);
        fork
            begin
                repeat (12) acc_tick(1'b1);
                acc_tick(1'b0);
            end
            repeat (30) dac_tick(1'b1);
        join
        expect_true(sb.size() == 0, $sformatf("%0d ant1 samples never read out", sb.size()));
        $display("errors: %0d value checks, %0d assertions", err_cnt, dut.props.fail_count);
        if (err_cnt == 0 && dut.props.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/tx_sample_pkg.sv
hw/tx_ctrl_pkg.sv
hw/cdc_flag_sync.sv
hw/iq_async_fifo.sv
hw/dac_intf.sv
testbench/dac_tx_props.sv
testbench/dac_tx_tb.sv
